/* project.f */
rtl/isa_pkg.sv
rtl/uop_pkg.sv
rtl/control_logic.sv
rtl/microcode_store.sv
rtl/reg_file.sv
rtl/mlu.sv
rtl/shifter.sv
rtl/cpu_core.sv
tb/tb_cpu_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_cpu_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "TEST FAILED" $(LOG) && grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_cpu_core.sv */
`default_nettype none

module tb_cpu_core;

  localparam int STEP_W       = 5;
  localparam int UADDR_W      = 1 + isa_pkg::OPCODE_W + STEP_W;
  localparam int TAKE_TIMEOUT = 32;

  logic                               n_clk;
  logic                               n_rst;
  logic [isa_pkg::OPCODE_W-1:0]       opword_opcode;
  logic [isa_pkg::DATA_W-1:0]         opword_imm;
  logic                               booted;
  logic [UADDR_W+uop_pkg::LANE_W-1:0] bootstrap_addr;
  logic [uop_pkg::BYTE_W-1:0]         bootstrap_data;
  logic                               bootstrap_we;
  wire                                opword_take;
  wire  [isa_pkg::DATA_W-1:0]         io_data;
  wire                                io_valid;

  // Instruction table with one opcode and immediate per entry
  logic [isa_pkg::OPCODE_W-1:0] tbl_op [$];
  logic [isa_pkg::DATA_W-1:0]   tbl_imm [$];
  // Expected io_data values in order
  logic [isa_pkg::DATA_W-1:0]   exp_io [$];
  // Software model of registers and zero flag
  logic [isa_pkg::DATA_W-1:0]   model_regs [isa_pkg::NUM_REGS];
  logic                         model_zero;
  logic                         out_patched;
  logic [31:0]                  lfsr;
  int                           io_count;
  int                           exp_count;

  cpu_core #(
    .STEP_W(STEP_W)
  ) dut0 (
    .n_clk         (n_clk),
    .n_rst         (n_rst),
    .opword_opcode (opword_opcode),
    .opword_imm    (opword_imm),
    .booted        (booted),
    .bootstrap_addr(bootstrap_addr),
    .bootstrap_data(bootstrap_data),
    .bootstrap_we  (bootstrap_we),
    .opword_take   (opword_take),
    .io_data       (io_data),
    .io_valid      (io_valid)
  );

  initial begin
    n_clk = 1'b0;
    forever #4 n_clk = ~n_clk;
  end

  task automatic stop_failed();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_failed();
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  task automatic rand_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  // Microword from its fields
  function automatic logic [31:0] uw(
    input uop_pkg::out_plane_e src,
    input uop_pkg::in_plane_e  dst,
    input int                  rsel,
    input isa_pkg::mlu_op_e    mop,
    input isa_pkg::shift_op_e  sop,
    input logic [7:0]          k,
    input logic                last,
    input isa_pkg::cond_e      csel
  );
    logic [31:0] w;
    w = '0;
    w[uop_pkg::CTRL_DATA_LSB +: uop_pkg::CTRL_DATA_W] = k;
    w[uop_pkg::REG_SEL_LSB +: uop_pkg::REG_SEL_W]     = rsel[1:0];
    w[uop_pkg::MLU_OP_LSB +: uop_pkg::MLU_OP_W]       = mop;
    w[uop_pkg::SHIFT_OP_LSB +: uop_pkg::SHIFT_OP_W]   = sop;
    w[uop_pkg::IN_PLANE_LSB +: uop_pkg::IN_PLANE_W]   = dst;
    w[uop_pkg::OUT_PLANE_LSB +: uop_pkg::OUT_PLANE_W] = src;
    w[uop_pkg::END_LSB]                               = last;
    w[uop_pkg::COND_SEL_LSB +: uop_pkg::COND_SEL_W]   = csel;
    return w;
  endfunction

  // Plain bus move
  function automatic logic [31:0] mv(
    input uop_pkg::out_plane_e src,
    input uop_pkg::in_plane_e  dst,
    input int                  rsel
  );
    return uw(src, dst, rsel, isa_pkg::MLU_ADD, isa_pkg::SHIFT_SHL, 8'h00, 1'b0,
              isa_pkg::COND_NONE);
  endfunction

  // Four byte lanes while the outputs stay quiet
  task automatic put_uword(input logic cond, input logic [isa_pkg::OPCODE_W-1:0] opc,
                           input logic [STEP_W-1:0] step, input logic [31:0] w);
    for (int lane = 0; lane < uop_pkg::UWORD_BYTES; lane++) begin
      @(negedge n_clk);
      compare("opword_take", 32'(opword_take), 32'd0);
      compare("io_valid", 32'(io_valid), 32'd0);
      bootstrap_addr = {cond, opc, step, 2'(lane)};
      bootstrap_data = w[lane*8 +: 8];
      bootstrap_we   = 1'b1;
    end
  endtask

  task automatic put_both(input logic [isa_pkg::OPCODE_W-1:0] opc, input int step,
                          input logic [31:0] w);
    put_uword(1'b0, opc, STEP_W'(step), w);
    put_uword(1'b1, opc, STEP_W'(step), w);
  endtask

  task automatic close_writes();
    @(negedge n_clk);
    compare("opword_take", 32'(opword_take), 32'd0);
    bootstrap_we = 1'b0;
  endtask

  // Microprograms of one family for all four registers
  task automatic load_family(input isa_pkg::op_e fam);
    logic [isa_pkg::OPCODE_W-1:0] opc;
    logic [31:0]                  fetch;
    isa_pkg::mlu_op_e             mop;
    isa_pkg::shift_op_e           sop;
    fetch = uw(uop_pkg::OUT_NONE, uop_pkg::IN_OPWORD, 0, isa_pkg::MLU_ADD,
               isa_pkg::SHIFT_SHL, 8'h00, 1'b1, isa_pkg::COND_NONE);
    // Family order follows the MLU and shift op order
    mop = isa_pkg::mlu_op_e'(2'(fam - isa_pkg::OP_ADD));
    sop = isa_pkg::shift_op_e'(2'(fam - isa_pkg::OP_SHL));
    for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
      opc = {fam, 2'(r)};
      case (fam)
        isa_pkg::OP_LDI: begin
          put_both(opc, 0, mv(uop_pkg::OUT_IMM, uop_pkg::IN_REG, r));
          put_both(opc, 1, fetch);
        end
        isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_XOR: begin
          put_both(opc, 0, mv(uop_pkg::OUT_REG, uop_pkg::IN_TMP0, 0));
          put_both(opc, 1, mv(uop_pkg::OUT_REG, uop_pkg::IN_TMP1, r));
          put_both(opc, 2, uw(uop_pkg::OUT_MLU, uop_pkg::IN_REG, 0, mop,
                              isa_pkg::SHIFT_SHL, 8'h00, 1'b0, isa_pkg::COND_NONE));
          put_both(opc, 3, fetch);
        end
        isa_pkg::OP_SHL, isa_pkg::OP_SHR, isa_pkg::OP_SAR, isa_pkg::OP_ROR: begin
          put_both(opc, 0, mv(uop_pkg::OUT_REG, uop_pkg::IN_TMP0, r));
          put_both(opc, 1, uw(uop_pkg::OUT_SHIFTER, uop_pkg::IN_REG, r, isa_pkg::MLU_ADD,
                              sop, 8'h00, 1'b0, isa_pkg::COND_NONE));
          put_both(opc, 2, fetch);
        end
        isa_pkg::OP_OUT: begin
          put_both(opc, 0, mv(uop_pkg::OUT_REG, uop_pkg::IN_IO, r));
          put_both(opc, 1, fetch);
        end
        isa_pkg::OP_OUTNZ: begin
          put_both(opc, 0, uw(uop_pkg::OUT_NONE, uop_pkg::IN_NONE, r, isa_pkg::MLU_ADD,
                              isa_pkg::SHIFT_SHL, 8'h00, 1'b0, isa_pkg::COND_ZERO));
          // Zero flag set means the output is skipped
          put_uword(1'b0, opc, STEP_W'(1), mv(uop_pkg::OUT_REG, uop_pkg::IN_IO, r));
          put_uword(1'b1, opc, STEP_W'(1), mv(uop_pkg::OUT_NONE, uop_pkg::IN_NONE, r));
          put_both(opc, 2, fetch);
        end
        default: put_both(opc, 0, fetch);
      endcase
    end
  endtask

  function automatic logic [7:0] alu_model(input isa_pkg::op_e fam, input int a, input int b);
    case (fam)
      isa_pkg::OP_ADD: return 8'((a + b) % 256);
      isa_pkg::OP_SUB: return 8'((a - b + 256) % 256);
      isa_pkg::OP_AND: return 8'(a & b);
      default:         return 8'(a ^ b);
    endcase
  endfunction

  function automatic logic [7:0] shift_model(input isa_pkg::op_e fam, input int v);
    case (fam)
      isa_pkg::OP_SHL: return 8'((v * 2) % 256);
      isa_pkg::OP_SHR: return 8'(v / 2);
      // Sign kept
      isa_pkg::OP_SAR: return 8'(v / 2 + (v >= 128 ? 128 : 0));
      // Bit 0 into bit 7
      default:         return 8'(v / 2 + (v % 2) * 128);
    endcase
  endfunction

  // Append an entry and step the model over it
  task automatic add_entry(input isa_pkg::op_e fam, input int r, input logic [7:0] imm);
    logic [7:0] res;
    tbl_op.push_back({fam, 2'(r)});
    tbl_imm.push_back(imm);
    case (fam)
      isa_pkg::OP_LDI: model_regs[r] = imm;
      isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_XOR: begin
        res = alu_model(fam, int'(model_regs[0]), int'(model_regs[r]));
        model_regs[0] = res;
        model_zero = (res == 8'h00);
      end
      isa_pkg::OP_SHL, isa_pkg::OP_SHR, isa_pkg::OP_SAR, isa_pkg::OP_ROR:
        model_regs[r] = shift_model(fam, int'(model_regs[r]));
      isa_pkg::OP_OUT: begin
        exp_io.push_back(out_patched ? 8'h5a : model_regs[r]);
        exp_count++;
      end
      isa_pkg::OP_OUTNZ: begin
        if (!model_zero) begin
          exp_io.push_back(model_regs[r]);
          exp_count++;
        end
      end
      default: ;
    endcase
  endtask

  // Shift a loaded value and read it back
  task automatic shift_case(input isa_pkg::op_e fam, input logic [7:0] v);
    add_entry(isa_pkg::OP_LDI, 3, v);
    add_entry(fam, 3, 8'h00);
    add_entry(isa_pkg::OP_OUT, 3, 8'h00);
  endtask

  // Immediate trails the opcode by one entry since OUT_IMM reads it after the opcode latch
  task automatic present(input int idx);
    opword_opcode = tbl_op[idx];
    opword_imm    = (idx > 0) ? tbl_imm[idx - 1] : 8'h00;
  endtask

  task automatic check_io();
    if (exp_io.size() == 0) begin
      $display("io_valid pulsed while no output was expected");
      stop_failed();
    end
    compare("io_data", 32'(io_data), 32'(exp_io.pop_front()));
    io_count++;
  endtask

  // Sample first and then drive on the falling edge
  task automatic run_table(input int first, input int last);
    int   idx;
    int   idle;
    logic take_now;
    logic take_seen;
    idx       = first;
    idle      = 0;
    // Reset fetch takes the first entry at the edge after booted rises
    take_seen = 1'b1;
    present(idx);
    while (idx < last) begin
      @(negedge n_clk);
      take_now = opword_take;
      if (io_valid) begin
        check_io();
      end
      if (take_seen) begin
        idx++;
        idle = 0;
        if (idx < last) begin
          present(idx);
        end
      end else begin
        idle++;
        if (idle > TAKE_TIMEOUT) begin
          $display("timeout: no opword_take for entry %0d in %0d cycles", idx, TAKE_TIMEOUT);
          stop_failed();
        end
      end
      take_seen = take_now;
    end
  endtask

  initial begin
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] edge_vals [4];
    int         first;
    n_rst          = 1'b0;
    booted         = 1'b0;
    opword_opcode  = '0;
    opword_imm     = '0;
    bootstrap_addr = '0;
    bootstrap_data = '0;
    bootstrap_we   = 1'b0;
    lfsr           = 32'ha22954ef;
    model_zero     = 1'b0;
    out_patched    = 1'b0;
    io_count       = 0;
    exp_count      = 0;
    edge_vals      = '{8'h3c, 8'h81, 8'hff, 8'h7f};
    foreach (model_regs[i]) begin
      model_regs[i] = 8'h00;
    end

    // Outputs stay quiet in reset
    repeat (10) begin
      @(negedge n_clk);
      compare("opword_take", 32'(opword_take), 32'd0);
      compare("io_valid", 32'(io_valid), 32'd0);
    end
    n_rst = 1'b1;

    for (int f = 0; f <= int'(isa_pkg::OP_OUTNZ); f++) begin
      load_family(isa_pkg::op_e'(4'(f)));
    end
    close_writes();
    booted = 1'b1;

    // Load and read back each register
    for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
      add_entry(isa_pkg::OP_LDI, r, edge_vals[r]);
      add_entry(isa_pkg::OP_OUT, r, 8'h00);
    end
    // r0 = r0 op r2 on random operands
    for (int f = int'(isa_pkg::OP_ADD); f <= int'(isa_pkg::OP_XOR); f++) begin
      rand_byte(a);
      rand_byte(b);
      add_entry(isa_pkg::OP_LDI, 0, a);
      add_entry(isa_pkg::OP_LDI, 2, b);
      add_entry(isa_pkg::op_e'(4'(f)), 2, 8'h00);
      add_entry(isa_pkg::OP_OUT, 0, 8'h00);
      add_entry(isa_pkg::OP_OUTNZ, 0, 8'h00);
    end
    // Each shift runs again with the top bit forced
    for (int f = int'(isa_pkg::OP_SHL); f <= int'(isa_pkg::OP_ROR); f++) begin
      rand_byte(a);
      shift_case(isa_pkg::op_e'(4'(f)), a);
      shift_case(isa_pkg::op_e'(4'(f)), {1'b1, a[6:0]});
    end
    // Equal SUB gives zero and OUTNZ stays silent
    rand_byte(a);
    add_entry(isa_pkg::OP_LDI, 0, a);
    add_entry(isa_pkg::OP_LDI, 1, a);
    add_entry(isa_pkg::OP_SUB, 1, 8'h00);
    add_entry(isa_pkg::OP_OUTNZ, 1, 8'h00);
    add_entry(isa_pkg::OP_OUT, 0, 8'h00);
    add_entry(isa_pkg::OP_LDI, 1, a | 8'h01);
    add_entry(isa_pkg::OP_XOR, 1, 8'h00);
    add_entry(isa_pkg::OP_OUTNZ, 0, 8'h00);
    add_entry(isa_pkg::OP_NOP, 0, 8'h00);
    run_table(0, tbl_op.size());

    // Patch OUT to a constant driver with booted low
    booted = 1'b0;
    for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
      put_both({isa_pkg::OP_OUT, 2'(r)}, 0,
               uw(uop_pkg::OUT_CTRL_DATA, uop_pkg::IN_IO, r, isa_pkg::MLU_ADD,
                  isa_pkg::SHIFT_SHL, 8'h5a, 1'b0, isa_pkg::COND_NONE));
    end
    close_writes();
    booted      = 1'b1;
    out_patched = 1'b1;
    first       = tbl_op.size();
    add_entry(isa_pkg::OP_LDI, 1, 8'h77);
    add_entry(isa_pkg::OP_OUT, 1, 8'h00);
    add_entry(isa_pkg::OP_OUT, 2, 8'h00);
    add_entry(isa_pkg::OP_NOP, 0, 8'h00);
    run_table(first, tbl_op.size());

    compare("io_valid count", 32'(io_count), 32'(exp_count));
    compare("pending outputs", 32'(exp_io.size()), 32'd0);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/cpu_core.sv */
`default_nettype none

module cpu_core #(
  parameter int STEP_W = 5,
  localparam int UADDR_W = 1 + isa_pkg::OPCODE_W + STEP_W
) (
  input  wire                                n_clk,
  input  wire                                n_rst,
  input  wire [isa_pkg::OPCODE_W-1:0]        opword_opcode,
  input  wire [isa_pkg::DATA_W-1:0]          opword_imm,
  input  wire                                booted,
  input  wire [UADDR_W+uop_pkg::LANE_W-1:0] bootstrap_addr,
  input  wire [uop_pkg::BYTE_W-1:0]          bootstrap_data,
  input  wire                                bootstrap_we,
  output logic                               opword_take,
  output logic [isa_pkg::DATA_W-1:0]         io_data,
  output logic                               io_valid
);

  // Control to store
  wire [UADDR_W-1:0]           uaddr;
  wire [uop_pkg::UWORD_W-1:0]  uword;

  // Internal bus and its receivers
  wire [isa_pkg::DATA_W-1:0]    bus;
  wire [isa_pkg::REG_IDX_W-1:0] reg_sel;
  wire                          reg_we;
  wire                          tmp0_we;
  wire                          tmp1_we;
  wire                          flag_we;

  // Datapath results and flags
  wire [isa_pkg::DATA_W-1:0]    reg_rdata;
  wire [isa_pkg::DATA_W-1:0]    tmp0;
  wire [isa_pkg::DATA_W-1:0]    tmp1;
  wire [isa_pkg::DATA_W-1:0]    mlu_result;
  wire [isa_pkg::DATA_W-1:0]    shift_result;
  wire isa_pkg::mlu_op_e        mlu_op;
  wire isa_pkg::shift_op_e      shift_op;
  wire                          zero;
  wire                          carry;
  wire                          negative;

  // Output port shows the bus directly
  assign io_data = bus;

  control_logic #(
    .STEP_W(STEP_W)
  ) control0 (
    .n_clk        (n_clk),
    .n_rst        (n_rst),
    .booted       (booted),
    .opword_opcode(opword_opcode),
    .opword_imm   (opword_imm),
    .uword        (uword),
    .reg_rdata    (reg_rdata),
    .tmp0         (tmp0),
    .mlu_result   (mlu_result),
    .shift_result (shift_result),
    .zero         (zero),
    .carry        (carry),
    .negative     (negative),
    .uaddr        (uaddr),
    .bus          (bus),
    .reg_sel      (reg_sel),
    .mlu_op       (mlu_op),
    .shift_op     (shift_op),
    .reg_we       (reg_we),
    .tmp0_we      (tmp0_we),
    .tmp1_we      (tmp1_we),
    .flag_we      (flag_we),
    .opword_take  (opword_take),
    .io_valid     (io_valid)
  );

  microcode_store #(
    .STEP_W(STEP_W)
  ) store0 (
    .n_clk         (n_clk),
    .uaddr         (uaddr),
    .bootstrap_addr(bootstrap_addr),
    .bootstrap_data(bootstrap_data),
    .bootstrap_we  (bootstrap_we),
    .uword         (uword)
  );

  reg_file reg_file0 (
    .n_clk    (n_clk),
    .n_rst    (n_rst),
    .bus      (bus),
    .reg_sel  (reg_sel),
    .reg_we   (reg_we),
    .tmp0_we  (tmp0_we),
    .tmp1_we  (tmp1_we),
    .reg_rdata(reg_rdata),
    .tmp0     (tmp0),
    .tmp1     (tmp1)
  );

  mlu mlu0 (
    .n_clk     (n_clk),
    .n_rst     (n_rst),
    .tmp0      (tmp0),
    .tmp1      (tmp1),
    .mlu_op    (mlu_op),
    .flag_we   (flag_we),
    .mlu_result(mlu_result),
    .zero      (zero),
    .carry     (carry),
    .negative  (negative)
  );

  shifter shifter0 (
    .tmp0        (tmp0),
    .shift_op    (shift_op),
    .shift_result(shift_result)
  );

endmodule

`default_nettype wire

/* rtl/shifter.sv */
`default_nettype none

module shifter (
  input  wire [isa_pkg::DATA_W-1:0]  tmp0,
  input  wire isa_pkg::shift_op_e    shift_op,
  output logic [isa_pkg::DATA_W-1:0] shift_result
);

  localparam int MSB = isa_pkg::DATA_W - 1;

  // Single-bit shifts, purely combinational
  always_comb begin
    case (shift_op)
      isa_pkg::SHIFT_SHL: shift_result = {tmp0[MSB-1:0], 1'b0};
      isa_pkg::SHIFT_SHR: shift_result = {1'b0, tmp0[MSB:1]};
      // Sign bit copied down
      isa_pkg::SHIFT_SAR: shift_result = {tmp0[MSB], tmp0[MSB:1]};
      // Bit 0 wraps to the top
      default:            shift_result = {tmp0[0], tmp0[MSB:1]};
    endcase
  end

endmodule

`default_nettype wire

/* rtl/mlu.sv */
`default_nettype none

module mlu (
  input  wire                        n_clk,
  input  wire                        n_rst,
  input  wire [isa_pkg::DATA_W-1:0]  tmp0,
  input  wire [isa_pkg::DATA_W-1:0]  tmp1,
  input  wire isa_pkg::mlu_op_e      mlu_op,
  input  wire                        flag_we,
  output logic [isa_pkg::DATA_W-1:0] mlu_result,
  output logic                       zero,
  output logic                       carry,
  output logic                       negative
);

  localparam int MSB = isa_pkg::DATA_W - 1;

  // One extra bit catches carry or borrow
  logic [isa_pkg::DATA_W:0] wide;
  logic                     carry_next;

  always_comb begin
    carry_next = 1'b0;
    case (mlu_op)
      isa_pkg::MLU_ADD: begin
        wide       = {1'b0, tmp0} + {1'b0, tmp1};
        carry_next = wide[isa_pkg::DATA_W];
      end
      isa_pkg::MLU_SUB: begin
        wide       = {1'b0, tmp0} - {1'b0, tmp1};
        // No borrow means tmp0 >= tmp1
        carry_next = ~wide[isa_pkg::DATA_W];
      end
      isa_pkg::MLU_AND: wide = {1'b0, tmp0 & tmp1};
      default:          wide = {1'b0, tmp0 ^ tmp1};
    endcase
  end

  assign mlu_result = wide[MSB:0];

  // Flags taken from the result on the bus
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      zero     <= 1'b0;
      carry    <= 1'b0;
      negative <= 1'b0;
    end else if (flag_we) begin
      zero     <= mlu_result == '0;
      carry    <= carry_next;
      negative <= mlu_result[MSB];
    end
  end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file (
  input  wire                           n_clk,
  input  wire                           n_rst,
  input  wire [isa_pkg::DATA_W-1:0]     bus,
  input  wire [isa_pkg::REG_IDX_W-1:0]  reg_sel,
  input  wire                           reg_we,
  input  wire                           tmp0_we,
  input  wire                           tmp1_we,
  output logic [isa_pkg::DATA_W-1:0]    reg_rdata,
  output logic [isa_pkg::DATA_W-1:0]    tmp0,
  output logic [isa_pkg::DATA_W-1:0]    tmp1
);

  logic [isa_pkg::DATA_W-1:0] regs [isa_pkg::NUM_REGS];

  // General registers, one port shared by read and write
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we) begin
      regs[reg_sel] <= bus;
    end
  end

  assign reg_rdata = regs[reg_sel];

  // Operand latches for MLU and shifter
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      tmp0 <= '0;
      tmp1 <= '0;
    end else begin
      if (tmp0_we) begin
        tmp0 <= bus;
      end
      if (tmp1_we) begin
        tmp1 <= bus;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/microcode_store.sv */
`default_nettype none

module microcode_store #(
  parameter int STEP_W = 5,
  localparam int UADDR_W = 1 + isa_pkg::OPCODE_W + STEP_W,
  localparam int DEPTH = 2 ** UADDR_W
) (
  input  wire                                n_clk,
  input  wire [UADDR_W-1:0]                  uaddr,
  input  wire [UADDR_W+uop_pkg::LANE_W-1:0] bootstrap_addr,
  input  wire [uop_pkg::BYTE_W-1:0]          bootstrap_data,
  input  wire                                bootstrap_we,
  output logic [uop_pkg::UWORD_W-1:0]        uword
);

  // Word storage split into byte lanes
  // Lane 0 holds bits 7..0
  logic [uop_pkg::UWORD_BYTES-1:0][uop_pkg::BYTE_W-1:0] mem [DEPTH];

  logic [UADDR_W-1:0]         boot_word;
  logic [uop_pkg::LANE_W-1:0] boot_lane;

  // Word index above, lane select in the low bits
  assign boot_word = bootstrap_addr[uop_pkg::LANE_W +: UADDR_W];
  assign boot_lane = bootstrap_addr[uop_pkg::LANE_W-1:0];

  // Bootstrap byte write
  always_ff @(posedge n_clk) begin
    if (bootstrap_we) begin
      mem[boot_word][boot_lane] <= bootstrap_data;
    end
  end

  // Asynchronous read
  // Control turns the word around within the same cycle
  assign uword = mem[uaddr];

endmodule

`default_nettype wire

/* rtl/control_logic.sv */
`default_nettype none

module control_logic #(
  parameter int STEP_W = 5,
  localparam int UADDR_W = 1 + isa_pkg::OPCODE_W + STEP_W
) (
  input  wire                           n_clk,
  input  wire                           n_rst,
  input  wire                           booted,
  input  wire [isa_pkg::OPCODE_W-1:0]   opword_opcode,
  input  wire [isa_pkg::DATA_W-1:0]     opword_imm,
  input  wire [uop_pkg::UWORD_W-1:0]    uword,
  input  wire [isa_pkg::DATA_W-1:0]     reg_rdata,
  input  wire [isa_pkg::DATA_W-1:0]     tmp0,
  input  wire [isa_pkg::DATA_W-1:0]     mlu_result,
  input  wire [isa_pkg::DATA_W-1:0]     shift_result,
  input  wire                           zero,
  input  wire                           carry,
  input  wire                           negative,
  output logic [UADDR_W-1:0]            uaddr,
  output logic [isa_pkg::DATA_W-1:0]    bus,
  output logic [isa_pkg::REG_IDX_W-1:0] reg_sel,
  output isa_pkg::mlu_op_e              mlu_op,
  output isa_pkg::shift_op_e            shift_op,
  output logic                          reg_we,
  output logic                          tmp0_we,
  output logic                          tmp1_we,
  output logic                          flag_we,
  output logic                          opword_take,
  output logic                          io_valid
);

  logic [STEP_W-1:0]               step_q;
  logic [isa_pkg::OPCODE_W-1:0]    opcode_q;
  isa_pkg::cond_e                  cond_sel_q;
  isa_pkg::cond_e                  cond_sel;
  logic                            cond;
  logic                            step_end;
  logic [uop_pkg::CTRL_DATA_W-1:0] ctrl_data;
  uop_pkg::in_plane_e              in_plane;
  uop_pkg::out_plane_e             out_plane;

  // Microword field extraction
  assign ctrl_data = uword[uop_pkg::CTRL_DATA_LSB +: uop_pkg::CTRL_DATA_W];
  assign reg_sel   = uword[uop_pkg::REG_SEL_LSB +: uop_pkg::REG_SEL_W];
  assign mlu_op    = isa_pkg::mlu_op_e'(uword[uop_pkg::MLU_OP_LSB +: uop_pkg::MLU_OP_W]);
  assign shift_op  = isa_pkg::shift_op_e'(uword[uop_pkg::SHIFT_OP_LSB +: uop_pkg::SHIFT_OP_W]);
  assign cond_sel  = isa_pkg::cond_e'(uword[uop_pkg::COND_SEL_LSB +: uop_pkg::COND_SEL_W]);
  assign step_end  = uop_pkg::misc_e'(uword[uop_pkg::END_LSB +: uop_pkg::END_W])
                     == uop_pkg::MISC_END;

  // Store contents are garbage before boot, so both planes read as idle
  assign in_plane  = booted
                     ? uop_pkg::in_plane_e'(uword[uop_pkg::IN_PLANE_LSB +: uop_pkg::IN_PLANE_W])
                     : uop_pkg::IN_NONE;
  assign out_plane = booted
                     ? uop_pkg::out_plane_e'(uword[uop_pkg::OUT_PLANE_LSB +: uop_pkg::OUT_PLANE_W])
                     : uop_pkg::OUT_NONE;

  // Step counter, back to zero on end flag or while unbooted
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      step_q <= '0;
    end else if (!booted || step_end) begin
      step_q <= '0;
    end else begin
      step_q <= step_q + STEP_W'(1);
    end
  end

  // Opcode latched when the microcode takes the next opword
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      opcode_q <= {isa_pkg::OP_NOP, {isa_pkg::REG_IDX_W{1'b0}}};
    end else if (opword_take) begin
      opcode_q <= opword_opcode;
    end
  end

  // Condition select for the following step
  // Holds its value while unbooted
  always_ff @(posedge n_clk or negedge n_rst) begin
    if (!n_rst) begin
      cond_sel_q <= isa_pkg::COND_NONE;
    end else if (booted) begin
      cond_sel_q <= cond_sel;
    end
  end

  // Flag mux into the address
  always_comb begin
    case (cond_sel_q)
      isa_pkg::COND_ZERO:  cond = zero;
      isa_pkg::COND_CARRY: cond = carry;
      isa_pkg::COND_NEG:   cond = negative;
      default:             cond = 1'b0;
    endcase
  end

  assign uaddr = {cond, opcode_q, step_q};

  // In plane decode
  assign reg_we      = in_plane == uop_pkg::IN_REG;
  assign tmp0_we     = in_plane == uop_pkg::IN_TMP0;
  assign tmp1_we     = in_plane == uop_pkg::IN_TMP1;
  assign opword_take = in_plane == uop_pkg::IN_OPWORD;
  assign io_valid    = in_plane == uop_pkg::IN_IO;

  // Flags follow whatever the MLU drives onto the bus
  assign flag_we = out_plane == uop_pkg::OUT_MLU;

  // Out plane decode, single driver of the bus
  always_comb begin
    case (out_plane)
      uop_pkg::OUT_REG:       bus = reg_rdata;
      uop_pkg::OUT_TMP0:      bus = tmp0;
      uop_pkg::OUT_MLU:       bus = mlu_result;
      uop_pkg::OUT_SHIFTER:   bus = shift_result;
      uop_pkg::OUT_CTRL_DATA: bus = ctrl_data;
      uop_pkg::OUT_IMM:       bus = opword_imm;
      default:                bus = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/uop_pkg.sv */
`default_nettype none

package uop_pkg;

  // Microword and its byte lanes for bootstrap writes
  localparam int UWORD_W     = 32;
  localparam int BYTE_W      = 8;
  localparam int UWORD_BYTES = UWORD_W / BYTE_W;
  localparam int LANE_W      = $clog2(UWORD_BYTES);

  // Field layout from bit 0 upward
  // Bits 31..23 are spare
  localparam int CTRL_DATA_LSB = 0;
  localparam int CTRL_DATA_W   = 8;
  localparam int REG_SEL_LSB   = 8;
  localparam int REG_SEL_W     = 2;
  localparam int MLU_OP_LSB    = 10;
  localparam int MLU_OP_W      = 2;
  localparam int SHIFT_OP_LSB  = 12;
  localparam int SHIFT_OP_W    = 2;
  localparam int IN_PLANE_LSB  = 14;
  localparam int IN_PLANE_W    = 3;
  localparam int OUT_PLANE_LSB = 17;
  localparam int OUT_PLANE_W   = 3;
  localparam int END_LSB       = 20;
  localparam int END_W         = 1;
  localparam int COND_SEL_LSB  = 21;
  localparam int COND_SEL_W    = 2;

  // Bus receivers
  typedef enum logic [2:0] {
    IN_NONE   = 3'd0,
    IN_REG    = 3'd1,
    IN_TMP0   = 3'd2,
    IN_TMP1   = 3'd3,
    IN_OPWORD = 3'd4,
    IN_IO     = 3'd5
  } in_plane_e;

  // Bus drivers
  typedef enum logic [2:0] {
    OUT_NONE      = 3'd0,
    OUT_REG       = 3'd1,
    OUT_TMP0      = 3'd2,
    OUT_MLU       = 3'd3,
    OUT_SHIFTER   = 3'd4,
    OUT_CTRL_DATA = 3'd5,
    OUT_IMM       = 3'd6
  } out_plane_e;

  // End of instruction marker
  typedef enum logic {
    MISC_NONE = 1'b0,
    MISC_END  = 1'b1
  } misc_e;

endpackage

`default_nettype wire

/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // Width of bus, registers and MLU
  localparam int DATA_W = 8;

  // Opword opcode: family in the top four bits, register in the low two
  localparam int OPCODE_W  = 6;
  localparam int REG_IDX_W = 2;
  localparam int NUM_REGS  = 4;

  // Instruction families
  // NOP doubles as the fetch program that runs after reset
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_LDI   = 4'd1,
    OP_ADD   = 4'd2,
    OP_SUB   = 4'd3,
    OP_AND   = 4'd4,
    OP_XOR   = 4'd5,
    OP_SHL   = 4'd6,
    OP_SHR   = 4'd7,
    OP_SAR   = 4'd8,
    OP_ROR   = 4'd9,
    OP_OUT   = 4'd10,
    OP_OUTNZ = 4'd11
  } op_e;

  // Flag feeding the condition bit of the microcode address
  typedef enum logic [1:0] {
    COND_NONE  = 2'd0,
    COND_ZERO  = 2'd1,
    COND_CARRY = 2'd2,
    COND_NEG   = 2'd3
  } cond_e;

  // MLU operations
  typedef enum logic [1:0] {
    MLU_ADD = 2'd0,
    MLU_SUB = 2'd1,
    MLU_AND = 2'd2,
    MLU_XOR = 2'd3
  } mlu_op_e;

  // One-bit shifts on tmp0
  typedef enum logic [1:0] {
    SHIFT_SHL = 2'd0,
    SHIFT_SHR = 2'd1,
    SHIFT_SAR = 2'd2,
    SHIFT_ROR = 2'd3
  } shift_op_e;

endpackage

`default_nettype wire
